// File: build.f
+incdir+logic
logic/pads_pkg.sv
logic/input_sync.sv
logic/mode_control.sv
logic/imem_loader.sv
logic/pads_top.sv
tb/tb_pads.sv

// File: logic/imem_loader.sv
`default_nettype none

`include "pads_cfg.svh"

module imem_loader (
	input  logic                    clk_int,
	input  logic                    mode_is_reset,
	input  logic [`PADS_BYTE_W-1:0] io_a_synched,
	input  logic                    imem_clock_synched,
	output pads_pkg::imem_word_t    imem
);

	// Address in the top bits, then two 24-bit pattern lanes
	logic [`PADS_SHIFT_W-1:0] shifter;
	logic                     clock_prev;
	logic                     load_edge;

	// Rising edge of the synchronised load clock
	assign load_edge = imem_clock_synched && !clock_prev;

	always_ff @(posedge clk_int) begin
		if (mode_is_reset) begin
			clock_prev <= 1'b0;
			shifter    <= '0;
		end else begin
			clock_prev <= imem_clock_synched;
			if (load_edge) begin
				// Oldest byte falls off the top
				shifter <= {shifter[`PADS_SHIFT_W-`PADS_BYTE_W-1:0], io_a_synched};
			end
		end
	end

	assign imem.addr = shifter[`PADS_SHIFT_W-1 -: `PADS_IMEM_ADDR_W];

	// Each lane is shifted in as 24 bits but memory holds 23, so the
	// top bit of each lane is dropped
	assign imem.data = {shifter[`PADS_PAT_W+1 +: `PADS_PAT_W],
		shifter[0 +: `PADS_PAT_W]};

	// Word may only move one cycle after a load clock edge or after reset
	a_shift_on_edge: assert property (
		@(posedge clk_int) disable iff (mode_is_reset)
		!$stable(shifter) |-> ($past(load_edge) || $past(mode_is_reset))
	) else $error("instruction shifter moved without a load clock edge");

endmodule

`default_nettype wire

// File: logic/input_sync.sv
`default_nettype none

`include "pads_cfg.svh"

module input_sync (
	input  logic                    clk_int,
	input  logic                    mode_is_reset,
	input  pads_pkg::mode_e         mode,
	input  logic [`PADS_BYTE_W-1:0] io_a_in,
	input  logic [`PADS_BYTE_W-1:0] io_b_in,
	input  logic                    pwm_low,
	input  logic                    pwm_high,
	output logic [`PADS_BYTE_W-1:0] io_a_synched,
	output logic                    imem_clock_synched,
	output logic                    imem_write_synched,
	output logic                    pwm_low_synched,
	output logic                    pwm_high_synched
);
	import pads_pkg::*;

	// Port A plus load clock, load write and the two pwm pins
	localparam int sync_w = `PADS_BYTE_W + 4;

	logic              imem_clock_gated;
	logic              imem_write_gated;
	logic [sync_w-1:0] sync_in;
	logic [sync_w-1:0] sync_meta;
	logic [sync_w-1:0] sync_out;

	// Load pins on port B only mean something in memory load mode
	assign imem_clock_gated = (mode == mode_memload) && io_b_in[0];
	assign imem_write_gated = (mode == mode_memload) && io_b_in[1];

	assign sync_in = {io_a_in, imem_clock_gated, imem_write_gated, pwm_low, pwm_high};

	always_ff @(posedge clk_int) begin
		if (mode_is_reset) begin
			sync_meta <= '0;
			sync_out  <= '0;
		end else begin
			sync_meta <= sync_in;
			sync_out  <= sync_meta;
		end
	end

	assign {io_a_synched, imem_clock_synched, imem_write_synched,
		pwm_low_synched, pwm_high_synched} = sync_out;

endmodule

`default_nettype wire

// File: logic/mode_control.sv
`default_nettype none

`include "pads_cfg.svh"

module mode_control (
	input  pads_pkg::mode_e         mode,
	input  logic [`PADS_BYTE_W-1:0] io_a_in,
	input  logic [`PADS_BYTE_W-1:0] io_b_in,
	input  logic                    sout_low,
	input  logic                    sout_high,
	input  logic [`PADS_BYTE_W-1:0] core_outputs,
	output pads_pkg::debug_bus_t    dbg_low,
	output pads_pkg::debug_bus_t    dbg_high,
	output pads_pkg::buf_reset_t    buf_resets,
	output logic [`PADS_BYTE_W-1:0] io_b_out,
	output logic                    io_b_lsb_oe
);
	import pads_pkg::*;

	debug_bus_t dbg_bus;
	logic       sel_high;
	logic       sout;

	// Serial bus fields as they sit on port A
	assign dbg_bus.sclk  = io_a_in[0];
	assign dbg_bus.ssel  = io_a_in[1];
	assign dbg_bus.sin   = io_a_in[2];
	assign dbg_bus.saddr = io_a_in[5:3];

	// Bit 6 picks the high buffer, else the low one
	assign sel_high = io_a_in[6];

	// Returned serial data of whichever buffer is addressed
	assign sout = sel_high ? sout_high : sout_low;

	always_comb begin
		dbg_low     = '0;
		dbg_high    = '0;
		buf_resets  = '0;
		io_b_out    = core_outputs;
		io_b_lsb_oe = 1'b0;

		case (mode)
			mode_reset: begin
				buf_resets = '1;
			end

			mode_debug: begin
				if (sel_high) begin
					dbg_high = dbg_bus;
				end else begin
					dbg_low = dbg_bus;
				end

				// Port B low nibble is an input here, resets come straight from it
				buf_resets.reset_pat             = io_b_in[2];
				buf_resets.reset_patternbuf_high = io_b_in[1];
				buf_resets.reset_patternbuf_low  = io_b_in[0];

				// Pull-up level on the input bits, serial readback on bit 4
				io_b_out[3:0] = 4'hf;
				io_b_out[4]   = sout;
			end

			mode_run: begin
				io_b_lsb_oe = 1'b1;
			end

			mode_memload: begin
				// Core and buffers held while the instruction memory fills
				buf_resets = '1;
			end

			default: begin
				buf_resets = '1;
			end
		endcase

		// Both buffers clocked at once would corrupt the unselected one
		assert (!(dbg_low.sclk && dbg_high.sclk))
			else $error("debug clock driven to both pattern buffers");

		// Driving the low nibble outside run mode fights the external pins
		assert (!io_b_lsb_oe || (mode == mode_run))
			else $error("port B low nibble enabled outside run mode");
	end

endmodule

`default_nettype wire

// File: logic/pads_cfg.svh
`ifndef PADS_CFG_SVH
`define PADS_CFG_SVH

// Width of port A and port B
`define PADS_BYTE_W 8

// Address into one pattern buffer over the serial bus
`define PADS_SADDR_W 3

// Instruction memory address
`define PADS_IMEM_ADDR_W 10

// One pattern half as stored in instruction memory
`define PADS_PAT_W 23

// Two pattern halves side by side
`define PADS_IMEM_DATA_W 46

// Address byte pair plus two 24-bit lanes
`define PADS_SHIFT_W 58

// Free-running divider, top bit is clock_out
`define PADS_CLKDIV_W 5

`endif

// File: logic/pads_pkg.sv
`default_nettype none

`include "pads_cfg.svh"

package pads_pkg;

	// Decoded from the two mode pins
	typedef enum logic [1:0] {
		mode_reset   = 2'd0,
		mode_debug   = 2'd1,
		mode_run     = 2'd2,
		mode_memload = 2'd3
	} mode_e;

	// Serial debug bus into one pattern buffer
	typedef struct packed {
		logic                     sclk;
		logic                     ssel;
		logic                     sin;
		logic [`PADS_SADDR_W-1:0] saddr;
	} debug_bus_t;

	// Instruction memory write port
	typedef struct packed {
		logic [`PADS_IMEM_ADDR_W-1:0] addr;
		logic [`PADS_IMEM_DATA_W-1:0] data;
	} imem_word_t;

	// Resets to the core and the two pattern buffers
	typedef struct packed {
		logic reset_pat;
		logic reset_patternbuf_low;
		logic reset_patternbuf_high;
	} buf_reset_t;

endpackage

`default_nettype wire

// File: logic/pads_top.sv
`default_nettype none

`include "pads_cfg.svh"

module pads_top (
	input  logic                    clk_int,
	input  logic                    mode_is_reset,
	input  logic [1:0]              modesel,
	input  logic [`PADS_BYTE_W-1:0] io_a_in,
	input  logic [`PADS_BYTE_W-1:0] io_b_in,
	input  logic                    pwm_low,
	input  logic                    pwm_high,
	input  logic                    sout_low,
	input  logic                    sout_high,
	input  logic [`PADS_BYTE_W-1:0] core_outputs,
	output pads_pkg::debug_bus_t    dbg_low,
	output pads_pkg::debug_bus_t    dbg_high,
	output pads_pkg::buf_reset_t    buf_resets,
	output logic [`PADS_BYTE_W-1:0] io_b_out,
	output logic                    io_b_lsb_oe,
	output pads_pkg::imem_word_t    imem,
	output logic                    imem_write,
	output logic                    pwm_low_synched,
	output logic                    pwm_high_synched,
	output logic [`PADS_BYTE_W-1:0] io_a_synched,
	output logic                    clock_out
);
	import pads_pkg::*;

	mode_e                     mode;
	logic                      imem_clock_synched;
	logic [`PADS_CLKDIV_W-1:0] clk_div;

	// Mode pins read straight, all four codes are valid
	assign mode = mode_e'(modesel);

	input_sync input_sync_i (
		.clk_int            (clk_int),
		.mode_is_reset      (mode_is_reset),
		.mode               (mode),
		.io_a_in            (io_a_in),
		.io_b_in            (io_b_in),
		.pwm_low            (pwm_low),
		.pwm_high           (pwm_high),
		.io_a_synched       (io_a_synched),
		.imem_clock_synched (imem_clock_synched),
		.imem_write_synched (imem_write),
		.pwm_low_synched    (pwm_low_synched),
		.pwm_high_synched   (pwm_high_synched)
	);

	mode_control mode_control_i (
		.mode         (mode),
		.io_a_in      (io_a_in),
		.io_b_in      (io_b_in),
		.sout_low     (sout_low),
		.sout_high    (sout_high),
		.core_outputs (core_outputs),
		.dbg_low      (dbg_low),
		.dbg_high     (dbg_high),
		.buf_resets   (buf_resets),
		.io_b_out     (io_b_out),
		.io_b_lsb_oe  (io_b_lsb_oe)
	);

	imem_loader imem_loader_i (
		.clk_int            (clk_int),
		.mode_is_reset      (mode_is_reset),
		.io_a_synched       (io_a_synched),
		.imem_clock_synched (imem_clock_synched),
		.imem               (imem)
	);

	// Divide by 32 for the clock_out pin
	always_ff @(posedge clk_int) begin
		if (mode_is_reset) begin
			clk_div <= '0;
		end else begin
			clk_div <= clk_div + 1'b1;
		end
	end

	assign clock_out = clk_div[`PADS_CLKDIV_W-1];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile the testbench and the RTL with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f build.f --top-module tb_pads -Mdir obj_dir

# A $fatal in the testbench gives a failing exit status here
./obj_dir/Vtb_pads

// File: tb/tb_pads.sv
`default_nettype none

`include "pads_cfg.svh"

module tb_pads;
	import pads_pkg::*;

	logic                    clk_int;
	logic                    mode_is_reset;
	logic [1:0]              modesel;
	logic [`PADS_BYTE_W-1:0] io_a_in;
	logic [`PADS_BYTE_W-1:0] io_b_in;
	logic                    pwm_low;
	logic                    pwm_high;
	logic                    sout_low;
	logic                    sout_high;
	logic [`PADS_BYTE_W-1:0] core_outputs;
	debug_bus_t              dbg_low;
	debug_bus_t              dbg_high;
	buf_reset_t              buf_resets;
	logic [`PADS_BYTE_W-1:0] io_b_out;
	logic                    io_b_lsb_oe;
	imem_word_t              imem;
	logic                    imem_write;
	logic                    pwm_low_synched;
	logic                    pwm_high_synched;
	logic [`PADS_BYTE_W-1:0] io_a_synched;
	logic                    clock_out;
	integer                  seed;

	pads_top dut_i (.*);

	initial begin
		clk_int = 1'b0;
		forever #20 clk_int = ~clk_int;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			stop_on_error($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_bus(input string name, input debug_bus_t exp, input debug_bus_t act);
		if (act !== exp)
			stop_on_error($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_resets(input string name, input buf_reset_t exp, input buf_reset_t act);
		if (act !== exp)
			stop_on_error($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_imem(input string name, input imem_word_t exp, input imem_word_t act);
		if (act !== exp)
			stop_on_error($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	// Address on top, then two 24-bit lanes whose top bits are spare
	function automatic imem_word_t word_from_shift(input logic [57:0] s);
		imem_word_t w;
		w.addr = s[57:48];
		w.data = {s[46:24], s[22:0]};
		return w;
	endfunction

	task automatic apply_reset();
		@(posedge clk_int);
		mode_is_reset <= 1'b1;
		repeat (10) @(posedge clk_int);
		mode_is_reset <= 1'b0;
	endtask

	task automatic drive(input mode_e m, input logic [7:0] a, input logic [7:0] b);
		@(posedge clk_int);
		modesel <= m;
		io_a_in <= a;
		io_b_in <= b;
		@(negedge clk_int);
	endtask

	// Called on the edge that releases reset
	task automatic test_divider();
		for (int i = 0; i < 33; i++) begin
			@(negedge clk_int);
			check_bit("clock_out", (i >= 16) && (i < 32), clock_out);
		end
	endtask

	task automatic test_debug_routing();
		logic [7:0] r;
		debug_bus_t exp;
		for (int sel = 0; sel < 2; sel++) begin
			r = $random(seed);
			drive(mode_debug, {r[7], sel[0], r[5:0]}, 8'h00);
			exp.sclk  = r[0];
			exp.ssel  = r[1];
			exp.sin   = r[2];
			exp.saddr = r[5:3];
			check_bus("dbg_low", sel ? '0 : exp, dbg_low);
			check_bus("dbg_high", sel ? exp : '0, dbg_high);
		end
		// All-ones debug bits reach neither buffer outside debug mode
		for (int m = 0; m < 4; m++) begin
			if (mode_e'(m) != mode_debug) begin
				drive(mode_e'(m), 8'h7f, 8'h00);
				check_bus("dbg_low", '0, dbg_low);
				check_bus("dbg_high", '0, dbg_high);
			end
		end
	endtask

	task automatic test_port_b_debug();
		logic [7:0] c;
		logic [1:0] s;
		for (int sel = 0; sel < 2; sel++) begin
			c = $random(seed);
			s = $random(seed);
			@(posedge clk_int);
			core_outputs <= c;
			sout_low     <= s[0];
			sout_high    <= s[1];
			drive(mode_debug, {1'b0, sel[0], 6'h00}, 8'h00);
			check_byte("io_b_out", {c[7:5], s[sel], 4'hf}, io_b_out);
			check_bit("io_b_lsb_oe", 1'b0, io_b_lsb_oe);
		end
	endtask

	task automatic test_run_mode();
		logic [7:0] c;
		for (int i = 0; i < 4; i++) begin
			c = $random(seed);
			@(posedge clk_int);
			core_outputs <= c;
			drive(mode_run, 8'h00, 8'h00);
			check_byte("io_b_out", c, io_b_out);
			check_bit("io_b_lsb_oe", 1'b1, io_b_lsb_oe);
			check_resets("buf_resets", '0, buf_resets);
		end
	endtask

	// Port A and the pwm pins reach the core two clocks after the pins move
	task automatic test_sync_latency();
		logic [7:0] a;
		logic [1:0] p;
		a = $random(seed);
		p = $random(seed);
		@(posedge clk_int);
		modesel  <= mode_run;
		io_a_in  <= ~a;
		io_b_in  <= 8'h03;
		pwm_low  <= ~p[0];
		pwm_high <= ~p[1];
		repeat (2) @(posedge clk_int);
		io_a_in  <= a;
		pwm_low  <= p[0];
		pwm_high <= p[1];
		for (int j = 0; j < 3; j++) begin
			@(negedge clk_int);
			check_byte("io_a_synched", (j < 2) ? ~a : a, io_a_synched);
			check_bit("pwm_low_synched", (j < 2) ? ~p[0] : p[0], pwm_low_synched);
			check_bit("pwm_high_synched", (j < 2) ? ~p[1] : p[1], pwm_high_synched);
			// Load pins are ignored outside memory load mode
			check_bit("imem_write", 1'b0, imem_write);
			check_imem("imem", '0, imem);
		end
	endtask

	task automatic test_resets();
		buf_reset_t exp;
		drive(mode_reset, 8'h00, 8'h00);
		check_resets("buf_resets", '1, buf_resets);
		drive(mode_memload, 8'h00, 8'h00);
		check_resets("buf_resets", '1, buf_resets);
		for (int i = 0; i < 8; i++) begin
			drive(mode_debug, 8'h00, {5'b0, i[2:0]});
			exp.reset_pat             = i[2];
			exp.reset_patternbuf_high = i[1];
			exp.reset_patternbuf_low  = i[0];
			check_resets("buf_resets", exp, buf_resets);
		end
	endtask

	task automatic test_imem_load();
		logic [57:0] model;
		logic [7:0]  b;
		imem_word_t  prev;
		imem_word_t  exp;
		int          cycles;
		model = '0;
		@(posedge clk_int);
		modesel <= mode_memload;
		io_b_in <= 8'h00;
		apply_reset();
		@(negedge clk_int);
		check_imem("imem", '0, imem);
		check_bit("imem_write", 1'b0, imem_write);
		for (int k = 0; k < 8; k++) begin
			b     = $random(seed);
			prev  = word_from_shift(model);
			model = {model[49:0], b};
			exp   = word_from_shift(model);
			@(posedge clk_int);
			io_a_in <= b;
			io_b_in <= 8'h01;
			// Three cycles of old word, new word on the fourth sample
			for (int j = 0; j < 3; j++) begin
				@(negedge clk_int);
				check_imem("imem", prev, imem);
			end
			@(negedge clk_int);
			check_imem("imem", exp, imem);
			@(posedge clk_int);
			io_b_in <= 8'h00;
			repeat (3) @(posedge clk_int);
		end
		@(posedge clk_int);
		io_b_in <= 8'h02;
		@(negedge clk_int);
		check_bit("imem_write", 1'b0, imem_write);
		@(negedge clk_int);
		check_bit("imem_write", 1'b0, imem_write);
		@(negedge clk_int);
		check_bit("imem_write", 1'b1, imem_write);
		cycles = 0;
		while ((imem !== exp) && (cycles < 20)) begin
			@(negedge clk_int);
			cycles++;
		end
		check_imem("imem", exp, imem);
		@(posedge clk_int);
		io_b_in <= 8'h00;
	endtask

	initial begin
		seed          = 32'he59f_7a6e;
		mode_is_reset = 1'b1;
		modesel       = mode_reset;
		io_a_in       = '0;
		io_b_in       = '0;
		pwm_low       = 1'b0;
		pwm_high      = 1'b0;
		sout_low      = 1'b0;
		sout_high     = 1'b0;
		core_outputs  = '0;
		apply_reset();
		test_divider();
		test_debug_routing();
		test_port_b_debug();
		test_run_mode();
		test_sync_latency();
		test_resets();
		test_imem_load();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
